/* rtl/dmmu_pkg.sv */
// Shared sizes, SPR map, TLB entry layout and types of the data MMU
// Referenced by scoped names from every RTL file

package dmmu_pkg;

   // Datapath sizes
   localparam int DATA_W     = 32;  // Operand and SPR data width
   localparam int SET_W      = 6;   // 64 TLB sets
   localparam int PAGE_W     = 13;  // 8 KB pages
   localparam int SPR_ADDR_W = 16;

   // SPR window of way 0, match regs then translate regs
   localparam logic [SPR_ADDR_W-1:0] SPR_DTLB_MR_BASE = 16'h0A00;
   localparam logic [SPR_ADDR_W-1:0] SPR_DTLB_TR_BASE = 16'h0A80;
   localparam logic [SPR_ADDR_W-1:0] SPR_DTLB_END     = 16'h0B00;  // First address past window

   // Match register layout, tag lives in [31:13]
   localparam int MR_VALID_BIT = 0;

   // Translate register layout, physical page number in [31:13]
   localparam int TR_CI_BIT  = 1;  // Cache inhibit
   localparam int TR_URE_BIT = 6;  // User read enable
   localparam int TR_UWE_BIT = 7;  // User write enable
   localparam int TR_SRE_BIT = 8;  // Supervisor read enable
   localparam int TR_SWE_BIT = 9;  // Supervisor write enable

   // Array addressed by the SPR bus
   typedef enum logic [1:0] {
      SEL_NONE  = 2'd0,  // Outside the TLB window or no access
      SEL_MATCH = 2'd1,
      SEL_TRANS = 2'd2
   } tlb_sel_e;

   // Read ack sequencing in the decoder
   typedef enum logic {
      SPR_IDLE   = 1'b0,
      SPR_RD_ACK = 1'b1   // RAM word available, ack the read
   } spr_state_e;

   // Registered RAM words and request fields, lookup to result
   typedef struct packed {
      logic [DATA_W-1:0] match;       // Match RAM word
      logic [DATA_W-1:0] trans;       // Translate RAM word
      logic [DATA_W-1:0] vaddr;       // Virtual address of the request
      logic              load;
      logic              store;
      logic              supervisor;
      tlb_sel_e          rd_sel;      // Array read by the SPR bus last cycle
      logic              valid;       // Lookup completes this cycle
   } tlb_rd_t;

endpackage

/* rtl/tlb_port_if.sv */
// RAM index and write controls from the SPR decoder to the TLB arrays
// Decoder drives every signal, lookup only samples them
`timescale 1ns/100ps

interface tlb_port_if;

   logic [dmmu_pkg::SET_W-1:0]  index;       // Shared index of both arrays
   logic                        match_we;
   logic                        trans_we;
   logic [dmmu_pkg::DATA_W-1:0] wdata;       // SPR write data
   logic                        spr_active;  // Bus owns the arrays this cycle
   dmmu_pkg::tlb_sel_e          rd_sel;      // Array returned on the bus

   modport decode (
      output index,
      output match_we,
      output trans_we,
      output wdata,
      output spr_active,
      output rd_sel
   );

   modport lookup (
      input index,
      input match_we,
      input trans_we,
      input wdata,
      input spr_active,
      input rd_sel
   );

endinterface

/* rtl/dtlb_spram.sv */
// Single-port TLB array, 64 words, synchronous read
// Same address for read and write, a write returns the old word
`timescale 1ns/100ps

module dtlb_spram (
   input  logic                        clk,
   input  logic [dmmu_pkg::SET_W-1:0]  addr_i,
   input  logic                        we_i,
   input  logic [dmmu_pkg::DATA_W-1:0] wdata_i,
   output logic [dmmu_pkg::DATA_W-1:0] rdata_o
);

   localparam int DEPTH = 2 ** dmmu_pkg::SET_W;

   // Storage, contents undefined until software fills it
   logic [dmmu_pkg::DATA_W-1:0] mem [DEPTH];

   // Write port
   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[addr_i] <= wdata_i;
      end
   end

   // Registered read, old data on a simultaneous write
   always_ff @(posedge clk) begin
      rdata_o <= mem[addr_i];
   end

endmodule

/* rtl/spr_tlb_decode.sv */
// SPR bus decoder for the DTLB window
// Picks the array and index, raises write enables and sequences the ack
`timescale 1ns/100ps

module spr_tlb_decode (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            spr_stb_i,
   input  logic                            spr_we_i,
   input  logic [dmmu_pkg::SPR_ADDR_W-1:0] spr_addr_i,
   input  logic [dmmu_pkg::DATA_W-1:0]     spr_wdata_i,
   input  logic [dmmu_pkg::DATA_W-1:0]     vaddr_i,
   tlb_port_if.decode                      tlb,
   output logic                            spr_ack_o
);

   dmmu_pkg::tlb_sel_e   sel;      // Array hit by the SPR address
   dmmu_pkg::spr_state_e state_q;
   logic                 tlb_acc;  // Strobed access inside the window
   logic                 rd_first; // First cycle of a TLB read
   logic                 wr_acc;

   // Address classification
   always_comb begin
      sel = dmmu_pkg::SEL_NONE;
      if (spr_addr_i >= dmmu_pkg::SPR_DTLB_MR_BASE &&
          spr_addr_i <  dmmu_pkg::SPR_DTLB_TR_BASE) begin
         sel = dmmu_pkg::SEL_MATCH;
      end else if (spr_addr_i >= dmmu_pkg::SPR_DTLB_TR_BASE &&
                   spr_addr_i <  dmmu_pkg::SPR_DTLB_END) begin
         sel = dmmu_pkg::SEL_TRANS;
      end
   end

   assign tlb_acc  = spr_stb_i & (sel != dmmu_pkg::SEL_NONE);
   assign wr_acc   = tlb_acc & spr_we_i & (state_q == dmmu_pkg::SPR_IDLE);
   assign rd_first = tlb_acc & ~spr_we_i & (state_q == dmmu_pkg::SPR_IDLE);

   // Read ack one cycle after the strobe, RAM output ready by then
   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= dmmu_pkg::SPR_IDLE;
      end else begin
         case (state_q)
            dmmu_pkg::SPR_IDLE: begin
               if (rd_first) begin
                  state_q <= dmmu_pkg::SPR_RD_ACK;
               end
            end
            default: state_q <= dmmu_pkg::SPR_IDLE;  // Master drops stb after ack
         endcase
      end
   end

   // Bus owns the index during a TLB access, else the virtual page index
   assign tlb.index = tlb_acc ? spr_addr_i[dmmu_pkg::SET_W-1:0]
                              : vaddr_i[dmmu_pkg::PAGE_W +: dmmu_pkg::SET_W];

   assign tlb.match_we   = wr_acc & (sel == dmmu_pkg::SEL_MATCH);
   assign tlb.trans_we   = wr_acc & (sel == dmmu_pkg::SEL_TRANS);
   assign tlb.wdata      = spr_wdata_i;
   assign tlb.spr_active = spr_stb_i;  // Any strobe blocks a lookup

   // Only the first read cycle names an array, so later cycles return zero
   assign tlb.rd_sel = rd_first ? sel : dmmu_pkg::SEL_NONE;

   // Writes and out-of-window accesses ack at once, reads one cycle late
   assign spr_ack_o = wr_acc |
                      (spr_stb_i & (sel == dmmu_pkg::SEL_NONE)) |
                      (spr_stb_i & (state_q == dmmu_pkg::SPR_RD_ACK));

endmodule

/* rtl/dtlb_lookup.sv */
// Match and translate arrays of the DTLB with the lookup request register
// RAM words and request fields leave together, one cycle after the index
`timescale 1ns/100ps

module dtlb_lookup (
   input  logic                        clk,
   input  logic                        rst,
   tlb_port_if.lookup                  tlb,
   input  logic                        req_i,
   input  logic [dmmu_pkg::DATA_W-1:0] vaddr_i,
   input  logic                        load_i,
   input  logic                        store_i,
   input  logic                        super_i,
   output dmmu_pkg::tlb_rd_t           rd_o
);

   logic [dmmu_pkg::DATA_W-1:0] match_word;  // Registered by the RAM
   logic [dmmu_pkg::DATA_W-1:0] trans_word;

   logic [dmmu_pkg::DATA_W-1:0] vaddr_q;
   logic                        load_q;
   logic                        store_q;
   logic                        super_q;
   logic                        valid_q;
   dmmu_pkg::tlb_sel_e          rd_sel_q;

   // Tag and valid bit
   dtlb_spram match_ram (
      .clk     (clk),
      .addr_i  (tlb.index),
      .we_i    (tlb.match_we),
      .wdata_i (tlb.wdata),
      .rdata_o (match_word)
   );

   // Physical page, cache inhibit and permissions
   dtlb_spram trans_ram (
      .clk     (clk),
      .addr_i  (tlb.index),
      .we_i    (tlb.trans_we),
      .wdata_i (tlb.wdata),
      .rdata_o (trans_word)
   );

   // Request payload, aligned with the RAM read
   always_ff @(posedge clk) begin
      vaddr_q <= vaddr_i;
      load_q  <= load_i;
      store_q <= store_i;
      super_q <= super_i;
   end

   // Control state
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q  <= 1'b0;
         rd_sel_q <= dmmu_pkg::SEL_NONE;
      end else begin
         valid_q  <= req_i & ~tlb.spr_active;  // Index belonged to the bus
         rd_sel_q <= tlb.rd_sel;               // Array read last cycle
      end
   end

   assign rd_o.match      = match_word;
   assign rd_o.trans      = trans_word;
   assign rd_o.vaddr      = vaddr_q;
   assign rd_o.load       = load_q;
   assign rd_o.store      = store_q;
   assign rd_o.supervisor = super_q;
   assign rd_o.rd_sel     = rd_sel_q;
   assign rd_o.valid      = valid_q;

endmodule

/* rtl/dmmu_result.sv */
// Lookup result logic, purely combinational
// Tag compare, permission check, physical address and SPR read data
`timescale 1ns/100ps

module dmmu_result (
   input  dmmu_pkg::tlb_rd_t           rd_i,
   output logic [dmmu_pkg::DATA_W-1:0] paddr_o,
   output logic                        ci_o,
   output logic                        miss_o,
   output logic                        fault_o,
   output logic                        rsp_valid_o,
   output logic [dmmu_pkg::DATA_W-1:0] spr_rdata_o
);

   localparam int TAG_W = dmmu_pkg::DATA_W - dmmu_pkg::PAGE_W;  // 19 tag bits

   logic [TAG_W-1:0] entry_tag;
   logic [TAG_W-1:0] req_tag;
   logic             entry_valid;
   logic             ure;
   logic             uwe;
   logic             sre;
   logic             swe;
   logic             rd_ok;   // Read allowed in the current mode
   logic             wr_ok;   // Write allowed in the current mode

   assign entry_tag   = rd_i.match[dmmu_pkg::DATA_W-1:dmmu_pkg::PAGE_W];
   assign req_tag     = rd_i.vaddr[dmmu_pkg::DATA_W-1:dmmu_pkg::PAGE_W];
   assign entry_valid = rd_i.match[dmmu_pkg::MR_VALID_BIT];

   // Permission nibble of the translate word
   assign ure = rd_i.trans[dmmu_pkg::TR_URE_BIT];
   assign uwe = rd_i.trans[dmmu_pkg::TR_UWE_BIT];
   assign sre = rd_i.trans[dmmu_pkg::TR_SRE_BIT];
   assign swe = rd_i.trans[dmmu_pkg::TR_SWE_BIT];

   assign rd_ok = rd_i.supervisor ? sre : ure;
   assign wr_ok = rd_i.supervisor ? swe : uwe;

   // Flags only while a lookup completes
   assign miss_o  = rd_i.valid & (~entry_valid | (entry_tag != req_tag));
   // Independent of miss, software ranks miss first
   assign fault_o = rd_i.valid & ((rd_i.load & ~rd_ok) | (rd_i.store & ~wr_ok));

   // Physical page joined with the page offset
   assign paddr_o = {rd_i.trans[dmmu_pkg::DATA_W-1:dmmu_pkg::PAGE_W],
                     rd_i.vaddr[dmmu_pkg::PAGE_W-1:0]};
   assign ci_o        = rd_i.trans[dmmu_pkg::TR_CI_BIT];
   assign rsp_valid_o = rd_i.valid;

   // SPR read data, zero when no TLB array was read
   always_comb begin
      case (rd_i.rd_sel)
         dmmu_pkg::SEL_MATCH: spr_rdata_o = rd_i.match;
         dmmu_pkg::SEL_TRANS: spr_rdata_o = rd_i.trans;
         default:             spr_rdata_o = '0;
      endcase
   end

endmodule

/* rtl/dmmu_top.sv */
// Data MMU top level, single-way DTLB with 64 sets of 8 KB pages
// Lookup port and SPR bus as plain ports, decode, arrays and result inside
`timescale 1ns/100ps

module dmmu_top (
   input  logic                            clk,
   input  logic                            rst,
   // Lookup request
   input  logic                            req_i,
   input  logic [dmmu_pkg::DATA_W-1:0]     vaddr_i,
   input  logic                            load_i,
   input  logic                            store_i,
   input  logic                            super_i,
   // Lookup response, one cycle later
   output logic                            rsp_valid_o,
   output logic [dmmu_pkg::DATA_W-1:0]     paddr_o,
   output logic                            ci_o,
   output logic                            miss_o,
   output logic                            fault_o,
   // SPR bus
   input  logic                            spr_stb_i,
   input  logic                            spr_we_i,
   input  logic [dmmu_pkg::SPR_ADDR_W-1:0] spr_addr_i,
   input  logic [dmmu_pkg::DATA_W-1:0]     spr_wdata_i,
   output logic [dmmu_pkg::DATA_W-1:0]     spr_rdata_o,
   output logic                            spr_ack_o
);

   tlb_port_if        tlb ();  // Decode to arrays
   dmmu_pkg::tlb_rd_t tlb_rd;  // Arrays to result

   spr_tlb_decode u_decode (
      .clk         (clk),
      .rst         (rst),
      .spr_stb_i   (spr_stb_i),
      .spr_we_i    (spr_we_i),
      .spr_addr_i  (spr_addr_i),
      .spr_wdata_i (spr_wdata_i),
      .vaddr_i     (vaddr_i),
      .tlb         (tlb.decode),
      .spr_ack_o   (spr_ack_o)
   );

   dtlb_lookup u_lookup (
      .clk     (clk),
      .rst     (rst),
      .tlb     (tlb.lookup),
      .req_i   (req_i),
      .vaddr_i (vaddr_i),
      .load_i  (load_i),
      .store_i (store_i),
      .super_i (super_i),
      .rd_o    (tlb_rd)
   );

   dmmu_result u_result (
      .rd_i        (tlb_rd),
      .paddr_o     (paddr_o),
      .ci_o        (ci_o),
      .miss_o      (miss_o),
      .fault_o     (fault_o),
      .rsp_valid_o (rsp_valid_o),
      .spr_rdata_o (spr_rdata_o)
   );

endmodule

/* verif/dmmu_checker.sv */
// Concurrent assertions on SPR ack and lookup response timing of the data MMU
// Bound to dmmu_top by the bind statement at the end of this file
`timescale 1ns/100ps

module dmmu_checker (
   input logic clk,
   input logic rst,
   input logic req_i,
   input logic spr_stb_i,
   input logic spr_we_i,
   input logic spr_ack_o,
   input logic rsp_valid_o
);

   // Bus and response quiet right after reset
   ack_low_after_reset: assert property (@(posedge clk)
      $fell(rst) |-> !spr_ack_o && !rsp_valid_o)
      else $error("ack or rsp_valid high right after reset");

   // Request without strobe completes next cycle
   rsp_after_request: assert property (@(posedge clk) disable iff (rst)
      (req_i && !spr_stb_i) |=> rsp_valid_o)
      else $error("lookup request without strobe gave no response");

   // Index belonged to the bus, request dropped
   no_rsp_during_strobe: assert property (@(posedge clk) disable iff (rst)
      (req_i && spr_stb_i) |=> !rsp_valid_o)
      else $error("lookup request during strobe gave a response");

   // Writes never wait
   write_ack_same_cycle: assert property (@(posedge clk) disable iff (rst)
      (spr_stb_i && spr_we_i) |-> spr_ack_o)
      else $error("SPR write not acked in its first cycle");

endmodule

bind dmmu_top dmmu_checker u_checker (
   .clk         (clk),
   .rst         (rst),
   .req_i       (req_i),
   .spr_stb_i   (spr_stb_i),
   .spr_we_i    (spr_we_i),
   .spr_ack_o   (spr_ack_o),
   .rsp_valid_o (rsp_valid_o)
);

/* verif/dmmu_tb.sv */
// Directed testbench of the data MMU, simulation top with a shadow TLB as reference
// Covers SPR access, translation, miss, permission faults and dropped requests
`timescale 1ns/100ps

module dmmu_tb;

   localparam int ACK_TIMEOUT = 10;  // Cycles allowed for an SPR ack

   logic        clk;
   logic        rst;
   logic        req;
   logic [31:0] vaddr;
   logic        load;
   logic        store;
   logic        supv;          // Supervisor mode
   logic        rsp_valid;
   logic [31:0] paddr;
   logic        ci;
   logic        miss;
   logic        fault;
   logic        spr_stb;
   logic        spr_we;
   logic [15:0] spr_addr;
   logic [31:0] spr_wdata;
   logic [31:0] spr_rdata;
   logic        spr_ack;

   logic [31:0] shadow_mr [64];  // Reference copy of the match RAM
   logic [31:0] shadow_tr [64];  // Reference copy of the translate RAM
   logic [31:0] rng;
   string       test_name;

   dmmu_top dut_i (
      .clk (clk), .rst (rst),
      .req_i (req), .vaddr_i (vaddr), .load_i (load), .store_i (store), .super_i (supv),
      .rsp_valid_o (rsp_valid), .paddr_o (paddr), .ci_o (ci), .miss_o (miss),
      .fault_o (fault),
      .spr_stb_i (spr_stb), .spr_we_i (spr_we), .spr_addr_i (spr_addr),
      .spr_wdata_i (spr_wdata), .spr_rdata_o (spr_rdata), .spr_ack_o (spr_ack)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;  // 20 ns period
   end

   function automatic logic [31:0] next_random(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Invalid entry or tag differs from vaddr[31:13]
   function automatic logic expect_miss(input logic [31:0] mr, input logic [31:0] va);
      return !mr[0] || (mr[31:13] != va[31:13]);
   endfunction

   // Bits 6..9 are ure, uwe, sre, swe
   function automatic logic expect_fault(input logic [31:0] tr, input logic ld,
                                         input logic st, input logic sv);
      logic rd_ok;
      logic wr_ok;
      rd_ok = sv ? tr[8] : tr[6];
      wr_ok = sv ? tr[9] : tr[7];
      return (ld && !rd_ok) || (st && !wr_ok);
   endfunction

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
         $display("Test FAILED");
         $fatal(1, "Mismatch in %s", test_name);
      end
   endtask

   task automatic fail_timeout(input string what);
      $display("Timeout in %s while waiting for %s", test_name, what);
      $display("Test FAILED");
      $fatal(1, "Timeout in %s", test_name);
   endtask

   // Strobe until ack, check ack latency, shadow follows TLB writes
   task automatic spr_write(input logic [15:0] addr, input logic [31:0] data);
      int cycles;
      @(posedge clk);
      #2;
      spr_stb   = 1'b1;
      spr_we    = 1'b1;
      spr_addr  = addr;
      spr_wdata = data;
      @(negedge clk);
      cycles = 0;
      while (spr_ack !== 1'b1 && cycles < ACK_TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (spr_ack !== 1'b1) fail_timeout("SPR write ack");
      check_value("write ack latency", 32'd0, cycles);
      @(posedge clk);  // RAM written here
      #2;
      spr_stb = 1'b0;
      spr_we  = 1'b0;
      if (addr >= dmmu_pkg::SPR_DTLB_MR_BASE && addr < dmmu_pkg::SPR_DTLB_TR_BASE)
         shadow_mr[addr[5:0]] = data;
      else if (addr >= dmmu_pkg::SPR_DTLB_TR_BASE && addr < dmmu_pkg::SPR_DTLB_END)
         shadow_tr[addr[5:0]] = data;
   endtask

   task automatic spr_read(input logic [15:0] addr, input int exp_latency,
                           output logic [31:0] data);
      int cycles;
      @(posedge clk);
      #2;
      spr_stb  = 1'b1;
      spr_we   = 1'b0;
      spr_addr = addr;
      @(negedge clk);
      cycles = 0;
      while (spr_ack !== 1'b1 && cycles < ACK_TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (spr_ack !== 1'b1) fail_timeout("SPR read ack");
      check_value("read ack latency", exp_latency, cycles);
      data = spr_rdata;  // Valid in the ack cycle
      @(posedge clk);
      #2;
      spr_stb = 1'b0;
   endtask

   // One request, response compared with the shadow model one cycle later
   task automatic check_lookup(input logic [31:0] va, input logic ld, input logic st,
                               input logic sv);
      logic [31:0] mr;
      logic [31:0] tr;
      mr = shadow_mr[va[18:13]];
      tr = shadow_tr[va[18:13]];
      @(posedge clk);
      #2;
      req   = 1'b1;
      vaddr = va;
      load  = ld;
      store = st;
      supv  = sv;
      @(posedge clk);  // Request and RAM index sampled
      #2;
      req = 1'b0;
      @(negedge clk);
      check_value("rsp_valid", 32'd1, 32'(rsp_valid));
      check_value("miss", 32'(expect_miss(mr, va)), 32'(miss));
      check_value("fault", 32'(expect_fault(tr, ld, st, sv)), 32'(fault));
      check_value("paddr", {tr[31:13], va[12:0]}, paddr);
      check_value("ci", 32'(tr[1]), 32'(ci));
   endtask

   task automatic test_reset_idle();
      test_name = "reset_idle";
      repeat (8) begin
         @(negedge clk);
         check_value("spr_ack", 32'd0, 32'(spr_ack));
         check_value("rsp_valid", 32'd0, 32'(rsp_valid));
      end
   endtask

   task automatic test_spr_readback();
      logic [5:0]  idx_list [8];
      logic [31:0] data;
      test_name = "spr_readback";
      for (int i = 0; i < 8; i++) begin
         rng = next_random(rng);
         idx_list[i] = rng[5:0];
         rng = next_random(rng);
         spr_write(dmmu_pkg::SPR_DTLB_MR_BASE | 16'(idx_list[i]), rng);
         rng = next_random(rng);
         spr_write(dmmu_pkg::SPR_DTLB_TR_BASE | 16'(idx_list[i]), rng);
      end
      for (int i = 0; i < 8; i++) begin
         spr_read(dmmu_pkg::SPR_DTLB_MR_BASE | 16'(idx_list[i]), 1, data);
         check_value("match word", shadow_mr[idx_list[i]], data);
         spr_read(dmmu_pkg::SPR_DTLB_TR_BASE | 16'(idx_list[i]), 1, data);
         check_value("translate word", shadow_tr[idx_list[i]], data);
      end
   endtask

   // Valid entry, perms field gives the fault cases
   task automatic fill_entry(input logic [31:0] va, input logic [18:0] tag, input logic vld,
                             input logic [31:0] ppn_src, input logic [3:0] perms);
      spr_write(dmmu_pkg::SPR_DTLB_MR_BASE | 16'(va[18:13]), {tag, 12'b0, vld});
      spr_write(dmmu_pkg::SPR_DTLB_TR_BASE | 16'(va[18:13]),
                {ppn_src[31:13], 3'b0, perms, 4'b0, ppn_src[0], 1'b0});
   endtask

   task automatic test_translate();
      logic [31:0] va;
      test_name = "translate";
      repeat (6) begin
         rng = next_random(rng);
         va  = rng;
         rng = next_random(rng);
         fill_entry(va, va[31:13], 1'b1, rng, 4'hF);
         check_lookup(va, 1'b1, 1'b0, 1'b1);
         check_lookup(va, 1'b0, 1'b1, 1'b0);
      end
   endtask

   task automatic test_miss();
      logic [31:0] va;
      test_name = "miss";
      repeat (4) begin
         rng = next_random(rng);
         va  = rng;
         fill_entry(va, va[31:13], 1'b0, rng, 4'hF);  // Tag matches, entry invalid
         check_lookup(va, 1'b1, 1'b0, 1'b1);
         fill_entry(va, va[31:13] ^ 19'h40000, 1'b1, rng, 4'hF);  // Top tag bit flipped
         check_lookup(va, 1'b1, 1'b0, 1'b0);
      end
   endtask

   task automatic test_permissions();
      logic [31:0] va;
      test_name = "permissions";
      repeat (12) begin
         rng = next_random(rng);
         va  = rng;
         rng = next_random(rng);
         fill_entry(va, va[31:13], 1'b1, rng, rng[9:6]);
         check_lookup(va, 1'b1, 1'b0, 1'b0);  // User load
         check_lookup(va, 1'b0, 1'b1, 1'b0);  // User store
         check_lookup(va, 1'b1, 1'b0, 1'b1);
         check_lookup(va, 1'b0, 1'b1, 1'b1);
      end
   endtask

   task automatic test_outside_and_strobe();
      logic [31:0] data;
      test_name = "outside_window";
      spr_read(16'h0C00, 0, data);
      check_value("rdata above window", 32'd0, data);
      spr_read(16'h09FF, 0, data);
      check_value("rdata below window", 32'd0, data);
      spr_write(16'h0B00, 32'hDEAD_BEEF);
      test_name = "lookup_during_strobe";
      @(posedge clk);
      #2;
      spr_stb  = 1'b1;          // TLB read, acked one cycle later
      spr_we   = 1'b0;
      spr_addr = dmmu_pkg::SPR_DTLB_MR_BASE | 16'h0005;
      req      = 1'b1;
      vaddr    = rng;
      load     = 1'b1;
      @(posedge clk);
      #2;
      req = 1'b0;
      @(negedge clk);
      check_value("rsp_valid", 32'd0, 32'(rsp_valid));
      check_value("read ack", 32'd1, 32'(spr_ack));
      @(posedge clk);
      #2;
      spr_stb = 1'b0;
      @(negedge clk);
      check_value("rsp_valid after strobe", 32'd0, 32'(rsp_valid));
   endtask

   initial begin
      rst       = 1'b1;
      req       = 1'b0;
      vaddr     = '0;
      load      = 1'b0;
      store     = 1'b0;
      supv      = 1'b0;
      spr_stb   = 1'b0;
      spr_we    = 1'b0;
      spr_addr  = '0;
      spr_wdata = '0;
      rng       = 32'h3a35_0a17;
      repeat (5) @(posedge clk);
      #2;
      rst = 1'b0;
      test_reset_idle();
      test_spr_readback();
      test_translate();
      test_miss();
      test_permissions();
      test_outside_and_strobe();
      $display("Test OK");
      $finish;
   end

endmodule

/* verilog.f */
rtl/dmmu_pkg.sv
rtl/tlb_port_if.sv
rtl/dtlb_spram.sv
rtl/spr_tlb_decode.sv
rtl/dtlb_lookup.sv
rtl/dmmu_result.sv
rtl/dmmu_top.sv
verif/dmmu_checker.sv
verif/dmmu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the DMMU testbench with Verilator, run it, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module dmmu_tb -f verilog.f -o dmmu_sim \
   && ./obj_dir/dmmu_sim 2>&1 | tee sim.log \
   || { echo "Build or simulation failed"; exit 1; }
grep -qx "Test OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
